// ==== Makefile ====
TOP := tb_fetch

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== compile.f ====
fetch_pkg.sv
rvc_pkg.sv
rvc_expander.sv
fetch_aligner.sv
fetch_addr_gen.sv
fetch_buffer.sv
fetch_top.sv
tb_fetch.sv

// ==== fetch_addr_gen.sv ====
`timescale 1ns/1ns

module fetch_addr_gen (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        hold_i,
    input  logic        redirect_i,
    input  logic [31:1] redirect_pc_i,
    input  logic        advance_i,
    input  logic        next_word_i,
    output logic [31:2] mem_addr_o
);

    logic [31:2] count_q;

    // Word counter, the target wins over a pending advance
    always_ff @(posedge clk_i) begin
        if (!rst_i)
            count_q <= '0;
        else if (redirect_i)
            count_q <= redirect_pc_i[31:2];
        else if (advance_i && !hold_i)
            count_q <= count_q + 30'd1;
    end

    // Look one word ahead to finish a split instruction
    assign mem_addr_o = next_word_i ? count_q + 30'd1 : count_q;

endmodule

// ==== fetch_aligner.sv ====
`timescale 1ns/1ns

module fetch_aligner (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        hold_i,
    input  logic        redirect_i,
    input  logic [31:1] redirect_pc_i,
    input  logic [31:0] mem_rdata_i,
    output logic        advance_o,
    output logic        next_word_o,
    output logic        push_o,
    output logic [31:2] push_instr_o,
    output logic        push_is_long_o,
    output logic [31:1] push_pc_o
);

    fetch_pkg::align_state_e state_q;
    fetch_pkg::align_state_e state_d;
    logic        run_q;
    logic [15:2] save_q;
    logic [31:1] pc_q;
    logic        long_lo;
    logic        long_hi;
    logic        go;
    logic [15:0] exp_in;
    logic [31:2] exp_out;

    assign long_lo = &mem_rdata_i[1:0];
    assign long_hi = &mem_rdata_i[17:16];

    assign exp_in = (state_q == fetch_pkg::ALIGN_HIGH) ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

    rvc_expander u_expander (
        .rvc_i   (exp_in),
        .instr_o (exp_out)
    );

    // Quiet in the first cycle out of reset and while redirecting
    assign go = run_q && !redirect_i;

    // Second half of a split sits in the following word
    assign next_word_o = (state_q == fetch_pkg::ALIGN_SPLIT);
    assign push_pc_o   = pc_q;

    always_comb begin
        advance_o      = 1'b0;
        push_o         = 1'b0;
        push_instr_o   = exp_out;
        push_is_long_o = 1'b0;
        state_d        = state_q;
        case (state_q)
            fetch_pkg::ALIGN_LOW: begin
                push_o         = go && !hold_i;
                advance_o      = go && long_lo;
                push_is_long_o = long_lo;
                if (long_lo)
                    push_instr_o = mem_rdata_i[31:2];
                else
                    state_d = fetch_pkg::ALIGN_HIGH;
            end
            fetch_pkg::ALIGN_HIGH: begin
                // A 32-bit start only gets saved here
                push_o    = go && !hold_i && !long_hi;
                advance_o = go && !long_hi;
                state_d   = long_hi ? fetch_pkg::ALIGN_SPLIT : fetch_pkg::ALIGN_LOW;
            end
            fetch_pkg::ALIGN_SPLIT: begin
                push_o         = go && !hold_i;
                advance_o      = go;
                push_is_long_o = 1'b1;
                push_instr_o   = {mem_rdata_i[15:0], save_q};
                state_d        = fetch_pkg::ALIGN_HIGH;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            run_q   <= 1'b0;
            state_q <= fetch_pkg::ALIGN_LOW;
            pc_q    <= '0;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                state_q <= redirect_pc_i[1] ? fetch_pkg::ALIGN_HIGH : fetch_pkg::ALIGN_LOW;
                pc_q    <= redirect_pc_i;
            end else if (run_q && !hold_i) begin
                state_q <= state_d;
                if (push_o)
                    pc_q <= pc_q + (push_is_long_o ? 31'd2 : 31'd1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == fetch_pkg::ALIGN_HIGH && go && !hold_i)
            save_q <= mem_rdata_i[31:18];
    end

    // Halfword position of the pc follows the state
    assert property (@(posedge clk_i) disable iff (!rst_i)
        pc_q[1] == (state_q != fetch_pkg::ALIGN_LOW));

    assert property (@(posedge clk_i) disable iff (!rst_i)
        state_q inside {fetch_pkg::ALIGN_LOW, fetch_pkg::ALIGN_HIGH, fetch_pkg::ALIGN_SPLIT});

endmodule

// ==== fetch_buffer.sv ====
`timescale 1ns/1ns

module fetch_buffer (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        flush_i,
    input  logic        push_i,
    input  logic [31:2] push_instr_i,
    input  logic        push_is_long_i,
    input  logic [31:1] push_pc_i,
    input  logic        credit_i,
    output logic        full_o,
    output logic        out_valid_o,
    output logic [31:2] out_instr_o,
    output logic        out_is_long_o,
    output logic [31:1] out_pc_o
);

    logic [31:2] instr_mem   [fetch_pkg::BUF_DEPTH];
    logic        is_long_mem [fetch_pkg::BUF_DEPTH];
    logic [31:1] pc_mem      [fetch_pkg::BUF_DEPTH];

    fetch_pkg::ptr_t    wr_ptr_q;
    fetch_pkg::ptr_t    rd_ptr_q;
    fetch_pkg::count_t  count_q;
    fetch_pkg::credit_t credit_q;
    logic               send;

    assign full_o = (count_q == fetch_pkg::count_t'(fetch_pkg::BUF_DEPTH));

    // Head leaves while a decoder slot is held
    assign send          = (count_q != '0) && (credit_q != '0) && !flush_i;
    assign out_valid_o   = send;
    assign out_instr_o   = instr_mem[rd_ptr_q];
    assign out_is_long_o = is_long_mem[rd_ptr_q];
    assign out_pc_o      = pc_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= fetch_pkg::credit_t'(fetch_pkg::DEC_CREDITS);
        end else begin
            // Credits survive a flush
            case ({credit_i, send})
                2'b10:   credit_q <= credit_q + fetch_pkg::credit_t'(1);
                2'b01:   credit_q <= credit_q - fetch_pkg::credit_t'(1);
                default: ;
            endcase
            if (flush_i) begin
                wr_ptr_q <= '0;
                rd_ptr_q <= '0;
                count_q  <= '0;
            end else begin
                if (push_i)
                    wr_ptr_q <= wr_ptr_q + fetch_pkg::ptr_t'(1);
                if (send)
                    rd_ptr_q <= rd_ptr_q + fetch_pkg::ptr_t'(1);
                case ({push_i, send})
                    2'b10:   count_q <= count_q + fetch_pkg::count_t'(1);
                    2'b01:   count_q <= count_q - fetch_pkg::count_t'(1);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            instr_mem[wr_ptr_q]   <= push_instr_i;
            is_long_mem[wr_ptr_q] <= push_is_long_i;
            pc_mem[wr_ptr_q]      <= push_pc_i;
        end
    end

    // The aligner must see full_o through its hold
    assert property (@(posedge clk_i) disable iff (!rst_i) push_i |-> !full_o);

    assert property (@(posedge clk_i) disable iff (!rst_i)
        credit_q <= fetch_pkg::credit_t'(fetch_pkg::DEC_CREDITS));

endmodule

// ==== fetch_pkg.sv ====
package fetch_pkg;

    //////////////////////////////////////////////////
    // Aligner position within the fetched word
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ALIGN_LOW   = 2'd0,
        ALIGN_HIGH  = 2'd1,
        // Upper half of previous word saved as start of a 32-bit instruction
        ALIGN_SPLIT = 2'd2
    } align_state_e;

    //////////////////////////////////////////////////
    // Instruction buffer and decoder credits
    //////////////////////////////////////////////////

    localparam int unsigned BUF_DEPTH   = 4;
    localparam int unsigned PTR_W       = 2;
    localparam int unsigned DEC_CREDITS = 2;
    localparam int unsigned CREDIT_W    = 2;

    typedef logic [PTR_W-1:0]    ptr_t;
    typedef logic [PTR_W:0]      count_t;
    typedef logic [CREDIT_W-1:0] credit_t;

    // Expansion of an unsupported compressed encoding
    localparam logic [31:2] INSTR_ILLEGAL = '0;

endpackage

// ==== fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
    input  logic        clk_i,
    input  logic        rst_i,
    output logic [31:2] mem_addr_o,
    input  logic [31:0] mem_rdata_i,
    input  logic        mem_wait_i,
    input  logic        redirect_i,
    input  logic [31:1] redirect_pc_i,
    output logic        out_valid_o,
    output logic [31:2] out_instr_o,
    output logic        out_is_long_o,
    output logic [31:1] out_pc_o,
    input  logic        credit_i
);

    logic        hold;
    logic        buf_full;
    logic        addr_advance;
    logic        addr_next_word;
    logic        aln_push;
    logic [31:2] aln_instr;
    logic        aln_is_long;
    logic [31:1] aln_pc;

    // Memory wait or a full queue freezes the front end
    assign hold = mem_wait_i | buf_full;

    fetch_addr_gen u_addr_gen (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .hold_i        (hold),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .advance_i     (addr_advance),
        .next_word_i   (addr_next_word),
        .mem_addr_o    (mem_addr_o)
    );

    fetch_aligner u_aligner (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .hold_i         (hold),
        .redirect_i     (redirect_i),
        .redirect_pc_i  (redirect_pc_i),
        .mem_rdata_i    (mem_rdata_i),
        .advance_o      (addr_advance),
        .next_word_o    (addr_next_word),
        .push_o         (aln_push),
        .push_instr_o   (aln_instr),
        .push_is_long_o (aln_is_long),
        .push_pc_o      (aln_pc)
    );

    fetch_buffer u_buffer (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .flush_i        (redirect_i),
        .push_i         (aln_push),
        .push_instr_i   (aln_instr),
        .push_is_long_i (aln_is_long),
        .push_pc_i      (aln_pc),
        .credit_i       (credit_i),
        .full_o         (buf_full),
        .out_valid_o    (out_valid_o),
        .out_instr_o    (out_instr_o),
        .out_is_long_o  (out_is_long_o),
        .out_pc_o       (out_pc_o)
    );

    // Memory address follows the aligner pc and runs one word ahead during a split
    assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_addr_o == aln_pc[31:2] +
            ((u_aligner.state_q == fetch_pkg::ALIGN_SPLIT) ? 30'd1 : 30'd0));

endmodule

// ==== rvc_expander.sv ====
`timescale 1ns/1ns

module rvc_expander (
    input  logic [15:0] rvc_i,
    output logic [31:2] instr_o
);

    rvc_pkg::rvc_quadrant_e quad;
    rvc_pkg::rvc_funct3_e   f3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rp_lo;
    logic [4:0]  rp_hi;
    logic        nz6;
    logic [2:0]  alu_f3;
    logic [11:0] imm6;
    logic [11:0] a4_off;
    logic [11:0] a16_off;
    logic [11:0] lw_off;
    logic [11:0] lwsp_off;
    logic [11:0] swsp_off;
    logic [20:0] jimm;
    logic [12:0] bimm;

    assign quad = rvc_pkg::rvc_quadrant_e'(rvc_i[1:0]);
    assign f3   = rvc_pkg::rvc_funct3_e'(rvc_i[15:13]);

    // Full and three-bit register fields, x8 to x15 for the short form
    assign rd    = rvc_i[11:7];
    assign rs2   = rvc_i[6:2];
    assign rp_lo = {2'b01, rvc_i[4:2]};
    assign rp_hi = {2'b01, rvc_i[9:7]};

    //////////////////////////////////////////////////
    // Immediates, reordered and extended
    //////////////////////////////////////////////////

    assign nz6      = |{rvc_i[12], rvc_i[6:2]};
    assign imm6     = {{7{rvc_i[12]}}, rvc_i[6:2]};
    assign a4_off   = {2'b00, rvc_i[10:7], rvc_i[12:11], rvc_i[5], rvc_i[6], 2'b00};
    assign a16_off  = {{3{rvc_i[12]}}, rvc_i[4:3], rvc_i[5], rvc_i[2], rvc_i[6], 4'd0};
    assign lw_off   = {5'd0, rvc_i[5], rvc_i[12:10], rvc_i[6], 2'b00};
    assign lwsp_off = {4'd0, rvc_i[3:2], rvc_i[12], rvc_i[6:4], 2'b00};
    assign swsp_off = {4'd0, rvc_i[8:7], rvc_i[12:9], 2'b00};
    assign jimm     = {{10{rvc_i[12]}}, rvc_i[8], rvc_i[10:9], rvc_i[6], rvc_i[7],
                       rvc_i[2], rvc_i[11], rvc_i[5:3], 1'b0};
    assign bimm     = {{5{rvc_i[12]}}, rvc_i[6:5], rvc_i[2], rvc_i[11:10], rvc_i[4:3], 1'b0};

    // SUB, XOR, OR, AND
    assign alu_f3 = (rvc_i[6:5] == 2'b00) ? 3'b000 :
                    (rvc_i[6:5] == 2'b01) ? 3'b100 :
                    (rvc_i[6:5] == 2'b10) ? 3'b110 : 3'b111;

    always_comb begin
        instr_o = fetch_pkg::INSTR_ILLEGAL;
        case (quad)
            rvc_pkg::C0: begin
                case (f3)
                    // Zero offset is reserved, also catches the all-zero halfword
                    rvc_pkg::F3_ADDI:
                        if (rvc_i[12:5] != 8'd0)
                            instr_o = {a4_off, 5'd2, 3'b000, rp_lo, rvc_pkg::OPC_OP_IMM};
                    rvc_pkg::F3_LW:
                        instr_o = {lw_off, rp_hi, 3'b010, rp_lo, rvc_pkg::OPC_LOAD};
                    rvc_pkg::F3_SW:
                        instr_o = {lw_off[11:5], rp_lo, rp_hi, 3'b010, lw_off[4:0],
                                   rvc_pkg::OPC_STORE};
                    default: ;
                endcase
            end
            rvc_pkg::C1: begin
                case (f3)
                    rvc_pkg::F3_ADDI: instr_o = {imm6, rd, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
                    rvc_pkg::F3_JAL:
                        instr_o = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd1,
                                   rvc_pkg::OPC_JAL};
                    rvc_pkg::F3_J:
                        instr_o = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd0,
                                   rvc_pkg::OPC_JAL};
                    rvc_pkg::F3_LW: instr_o = {imm6, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
                    // rd of x2 selects ADDI16SP
                    rvc_pkg::F3_LUI:
                        if (nz6)
                            instr_o = (rd == 5'd2) ?
                                {a16_off, 5'd2, 3'b000, 5'd2, rvc_pkg::OPC_OP_IMM} :
                                {{15{rvc_i[12]}}, rvc_i[6:2], rd, rvc_pkg::OPC_LUI};
                    rvc_pkg::F3_ALU: begin
                        case (rvc_i[11:10])
                            2'b00: if (!rvc_i[12])
                                instr_o = {7'b0000000, rs2, rp_hi, 3'b101, rp_hi,
                                           rvc_pkg::OPC_OP_IMM};
                            2'b01: if (!rvc_i[12])
                                instr_o = {7'b0100000, rs2, rp_hi, 3'b101, rp_hi,
                                           rvc_pkg::OPC_OP_IMM};
                            2'b10: instr_o = {imm6, rp_hi, 3'b111, rp_hi, rvc_pkg::OPC_OP_IMM};
                            default: if (!rvc_i[12])
                                instr_o = {(alu_f3 == 3'b000) ? 7'b0100000 : 7'b0000000,
                                           rp_lo, rp_hi, alu_f3, rp_hi, rvc_pkg::OPC_OP};
                        endcase
                    end
                    rvc_pkg::F3_SW:
                        instr_o = {bimm[12], bimm[10:5], 5'd0, rp_hi, 3'b000, bimm[4:1],
                                   bimm[11], rvc_pkg::OPC_BRANCH};
                    default:
                        instr_o = {bimm[12], bimm[10:5], 5'd0, rp_hi, 3'b001, bimm[4:1],
                                   bimm[11], rvc_pkg::OPC_BRANCH};
                endcase
            end
            rvc_pkg::C2: begin
                case (f3)
                    rvc_pkg::F3_ADDI:
                        if (!rvc_i[12])
                            instr_o = {7'd0, rs2, rd, 3'b001, rd, rvc_pkg::OPC_OP_IMM};
                    rvc_pkg::F3_LW:
                        if (rd != 5'd0)
                            instr_o = {lwsp_off, 5'd2, 3'b010, rd, rvc_pkg::OPC_LOAD};
                    // JR and MV, then EBREAK, JALR and ADD
                    rvc_pkg::F3_ALU: begin
                        if (!rvc_i[12] && rs2 == 5'd0 && rd != 5'd0)
                            instr_o = {12'd0, rd, 3'b000, 5'd0, rvc_pkg::OPC_JALR};
                        else if (!rvc_i[12] && rs2 != 5'd0)
                            instr_o = {7'd0, rs2, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP};
                        else if (rvc_i[12] && rs2 != 5'd0)
                            instr_o = {7'd0, rs2, rd, 3'b000, rd, rvc_pkg::OPC_OP};
                        else if (rvc_i[12] && rd != 5'd0)
                            instr_o = {12'd0, rd, 3'b000, 5'd1, rvc_pkg::OPC_JALR};
                        else if (rvc_i[12])
                            instr_o = {12'd1, 5'd0, 3'b000, 5'd0, rvc_pkg::OPC_SYSTEM};
                    end
                    rvc_pkg::F3_SW:
                        instr_o = {swsp_off[11:5], rs2, 5'd2, 3'b010, swsp_off[4:0],
                                   rvc_pkg::OPC_STORE};
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== rvc_pkg.sv ====
package rvc_pkg;

    // Bits 1:0 of a halfword, 2'b11 marks a 32-bit instruction instead
    typedef enum logic [1:0] {
        C0 = 2'b00,
        C1 = 2'b01,
        C2 = 2'b10
    } rvc_quadrant_e;

    // Bits 15:13, named by main use
    // The same code means a different operation in each quadrant
    typedef enum logic [2:0] {
        F3_ADDI = 3'b000,  // C0 ADDI4SPN, C1 ADDI, C2 SLLI
        F3_JAL  = 3'b001,
        F3_LW   = 3'b010,  // C0 LW, C1 LI, C2 LWSP
        F3_LUI  = 3'b011,  // C1 LUI and ADDI16SP
        F3_ALU  = 3'b100,  // C1 shifts and logic, C2 JR, MV, ADD
        F3_J    = 3'b101,
        F3_SW   = 3'b110,  // C0 SW, C1 BEQZ, C2 SWSP
        F3_BNEZ = 3'b111
    } rvc_funct3_e;

    //////////////////////////////////////////////////
    // Base opcodes, bits 6:2 of the expanded form
    //////////////////////////////////////////////////

    localparam logic [4:0] OPC_OP_IMM = 5'b00100;
    localparam logic [4:0] OPC_OP     = 5'b01100;
    localparam logic [4:0] OPC_LUI    = 5'b01101;
    localparam logic [4:0] OPC_LOAD   = 5'b00000;
    localparam logic [4:0] OPC_STORE  = 5'b01000;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

endpackage

// ==== tb_fetch.sv ====
`timescale 1ns/1ns

module tb_fetch;

    localparam int unsigned HALVES          = 512;
    localparam int unsigned TOTAL_INSTR     = 120 + 200 + 150 + 200 + 120;
    localparam int unsigned WATCHDOG_CYCLES = TOTAL_INSTR * 40 + 2000;

    logic        clk_i;
    logic        rst_i;
    logic [31:2] mem_addr_o;
    logic [31:0] mem_rdata_i;
    logic        mem_wait_i;
    logic        redirect_i;
    logic [31:1] redirect_pc_i;
    logic        out_valid_o;
    logic [31:2] out_instr_o;
    logic        out_is_long_o;
    logic [31:1] out_pc_o;
    logic        credit_i;

    // Program as a halfword stream, with instruction starts marked
    logic [15:0] hmem     [HALVES];
    logic        is_start [HALVES];

    integer      seed;
    int          errors;
    int          test_errors;
    int          failed_tests;
    int          checked;
    int          slots;
    int          pending;
    int          credit_wait;
    logic [31:1] model_pc;

    fetch_top dut (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .mem_addr_o    (mem_addr_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_wait_i    (mem_wait_i),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .out_valid_o   (out_valid_o),
        .out_instr_o   (out_instr_o),
        .out_is_long_o (out_is_long_o),
        .out_pc_o      (out_pc_o),
        .credit_i      (credit_i)
    );

    // 256-word memory, wraps on the word address
    assign mem_rdata_i = {hmem[{mem_addr_o[9:2], 1'b1}], hmem[{mem_addr_o[9:2], 1'b0}]};

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic int unsigned urand(input int unsigned n);
        urand = $unsigned($random(seed)) % n;
    endfunction

    //////////////////////////////////////////////////
    // Program generation
    //////////////////////////////////////////////////

    // C.LI, C.ADDI, C.MV, C.ADD, C.SLLI, C.LW, C.SW
    function automatic logic [15:0] gen_rvc();
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [5:0]  imm;
        logic [2:0]  rp_a;
        logic [2:0]  rp_b;
        logic [4:0]  off;
        int unsigned op;
        rd   = 5'(urand(32));
        rs2  = 5'(urand(31) + 1);
        imm  = 6'(urand(64));
        rp_a = 3'(urand(8));
        rp_b = 3'(urand(8));
        off  = 5'(urand(32));
        op   = urand(7);
        case (op)
            0: gen_rvc = {3'b010, imm[5], rd, imm[4:0], 2'b01};
            1: gen_rvc = {3'b000, imm[5], rd, imm[4:0], 2'b01};
            2: gen_rvc = {3'b100, 1'b0, rd, rs2, 2'b10};
            3: gen_rvc = {3'b100, 1'b1, rd, rs2, 2'b10};
            4: gen_rvc = {3'b000, 1'b0, rd, imm[4:0], 2'b10};
            5: gen_rvc = {3'b010, off[3:1], rp_a, off[0], off[4], rp_b, 2'b00};
            default: gen_rvc = {3'b110, off[3:1], rp_a, off[0], off[4], rp_b, 2'b00};
        endcase
    endfunction

    // Mode 0 long only, 1 mixed, 2 compressed with some zero halfwords
    task automatic fill_memory(input int mode);
        int          h;
        logic [31:0] word;
        h = 0;
        while (h < HALVES) begin
            is_start[h] = 1'b1;
            if (mode == 2) begin
                hmem[h] = (urand(8) == 0) ? 16'h0000 : gen_rvc();
                h = h + 1;
            end else if ((mode == 0 || urand(2) == 0) && h < HALVES - 1) begin
                word          = $random(seed);
                hmem[h]       = {word[15:2], 2'b11};
                hmem[h+1]     = word[31:16];
                is_start[h+1] = 1'b0;
                h = h + 2;
            end else begin
                hmem[h] = gen_rvc();
                h = h + 1;
            end
        end
    endtask

    function automatic logic [31:1] pick_target();
        int unsigned h;
        h = urand(HALVES);
        while (!is_start[h])
            h = (h + 1) % HALVES;
        pick_target = 31'(h);
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [31:2] expand_rvc(input logic [15:0] h);
        logic [11:0] simm;
        logic [6:0]  uoff;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rp_lo;
        logic [4:0]  rp_hi;
        simm  = {{6{h[12]}}, h[12], h[6:2]};
        uoff  = {h[5], h[12:10], h[6], 2'b00};
        rd    = h[11:7];
        rs2   = h[6:2];
        rp_lo = {2'b01, h[4:2]};
        rp_hi = {2'b01, h[9:7]};
        expand_rvc = fetch_pkg::INSTR_ILLEGAL;
        case ({h[15:13], h[1:0]})
            5'b010_01: expand_rvc = {simm, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
            5'b000_01: expand_rvc = {simm, rd, 3'b000, rd, rvc_pkg::OPC_OP_IMM};
            5'b000_10:
                if (!h[12])
                    expand_rvc = {7'd0, rs2, rd, 3'b001, rd, rvc_pkg::OPC_OP_IMM};
            5'b100_10:
                if (rs2 != 5'd0)
                    expand_rvc = h[12] ? {7'd0, rs2, rd, 3'b000, rd, rvc_pkg::OPC_OP} :
                                         {7'd0, rs2, 5'd0, 3'b000, rd, rvc_pkg::OPC_OP};
            5'b010_00: expand_rvc = {5'd0, uoff, rp_hi, 3'b010, rp_lo, rvc_pkg::OPC_LOAD};
            5'b110_00:
                expand_rvc = {5'd0, uoff[6:5], rp_lo, rp_hi, 3'b010, uoff[4:0],
                              rvc_pkg::OPC_STORE};
            default: ;
        endcase
    endfunction

    task automatic check_instr(input logic [31:2] exp, input logic [31:2] got);
        if (got !== exp) begin
            $display("[FAIL] out_instr_o expected %h got %h", exp, got);
            test_errors++;
        end
    endtask

    task automatic check_is_long(input logic exp, input logic got);
        if (got !== exp) begin
            $display("[FAIL] out_is_long_o expected %h got %h", exp, got);
            test_errors++;
        end
    endtask

    task automatic check_pc(input logic [31:1] exp, input logic [31:1] got);
        if (got !== exp) begin
            $display("[FAIL] out_pc_o expected %h got %h", exp, got);
            test_errors++;
        end
    endtask

    // Boundary walk, one instruction from the model pc
    task automatic check_output();
        logic [15:0] lo;
        logic [15:0] hi;
        logic [31:1] next_pc;
        logic        exp_long;
        logic [31:2] exp_instr;
        lo        = hmem[model_pc[9:1]];
        next_pc   = model_pc + 31'd1;
        hi        = hmem[next_pc[9:1]];
        exp_long  = (lo[1:0] == 2'b11);
        exp_instr = exp_long ? {hi, lo[15:2]} : expand_rvc(lo);
        check_pc(model_pc, out_pc_o);
        check_instr(exp_instr, out_instr_o);
        check_is_long(exp_long, out_is_long_o);
        model_pc = model_pc + (exp_long ? 31'd2 : 31'd1);
        checked++;
    endtask

    //////////////////////////////////////////////////
    // Test sequencing
    //////////////////////////////////////////////////

    task automatic run_test(input int num, input string name, input int mode,
                            input int count, input int gap_max, input int redir_rate);
        int got;
        got         = 0;
        test_errors = 0;
        @(posedge clk_i);
        #2;
        rst_i      = 1'b0;
        mem_wait_i = 1'b0;
        redirect_i = 1'b0;
        credit_i   = 1'b0;
        fill_memory(mode);
        model_pc    = '0;
        slots       = fetch_pkg::DEC_CREDITS;
        pending     = 0;
        credit_wait = 0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_i = 1'b1;
        while (got < count) begin
            @(posedge clk_i);
            #2;
            mem_wait_i = (urand(4) == 0);
            redirect_i = 1'b0;
            if (redir_rate > 0) begin
                if (urand(redir_rate) == 0) begin
                    redirect_i    = 1'b1;
                    redirect_pc_i = pick_target();
                end
            end
            // Decoder returns one slot at a time, each after its own delay
            credit_i = 1'b0;
            if (pending > 0) begin
                if (credit_wait == 0) begin
                    credit_i    = 1'b1;
                    pending     = pending - 1;
                    credit_wait = urand(gap_max + 1);
                end else begin
                    credit_wait = credit_wait - 1;
                end
            end
            @(negedge clk_i);
            if (out_valid_o) begin
                if (slots == 0) begin
                    $display("Credit overrun: instruction sent with no decoder slot held");
                    test_errors++;
                end else begin
                    slots = slots - 1;
                end
                if (pending == 0)
                    credit_wait = urand(gap_max + 1);
                pending = pending + 1;
                check_output();
                got++;
            end
            if (redirect_i)
                model_pc = redirect_pc_i;
            if (credit_i)
                slots = slots + 1;
        end
        $display("Test %0d %s: %0d instructions, %0d errors", num, name, got, test_errors);
        errors = errors + test_errors;
        if (test_errors != 0)
            failed_tests++;
    endtask

    initial begin
        seed          = 42;
        errors        = 0;
        failed_tests  = 0;
        checked       = 0;
        rst_i         = 1'b0;
        mem_wait_i    = 1'b0;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        credit_i      = 1'b0;
        run_test(1, "straight_long", 0, 120, 3, 0);
        run_test(2, "mixed_split", 1, 200, 3, 0);
        run_test(3, "rvc_expand", 2, 150, 3, 0);
        run_test(4, "redirect", 1, 200, 3, 10);
        run_test(5, "backpressure", 1, 120, 32, 0);
        $display("Summary: 5 tests, %0d failed, %0d instructions checked, %0d errors",
                 failed_tests, checked, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    // Bounded by the planned instruction count
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Watchdog expired: the DUT stopped delivering instructions");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
